/* rtl/mbox_pkg.sv */
// shared definitions for the two-port mailbox
// widths, fifo depth, register index enum
// per-port request / response structs
// fixed words returned on special reads
`default_nettype none

package mbox_pkg;

  // --------------------
  // sizes
  // --------------------
  localparam int unsigned DATA_W     = 32;                 // register and mailbox word
  localparam int unsigned MBOX_DEPTH = 8;                  // words per direction
  localparam int unsigned PTR_W      = $clog2(MBOX_DEPTH); // fifo pointer width
  localparam int unsigned USAGE_W    = PTR_W + 1;          // one more bit so full == MBOX_DEPTH
  localparam int unsigned IDX_W      = 4;                  // register index, 16 slots

  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [USAGE_W-1:0] usage_t;

  // register map of one port, indices 10..15 are unmapped
  typedef enum logic [IDX_W-1:0] {
    MBOXW  = 4'd0, // push a word to the peer
    MBOXR  = 4'd1, // pop a word from the peer
    STATUS = 4'd2, // empty / full / threshold flags
    ERROR  = 4'd3, // clear on read
    WIRQT  = 4'd4, // outbound usage threshold
    RIRQT  = 4'd5, // inbound usage threshold
    IRQS   = 4'd6, // sticky irq status, write 1 to clear
    IRQEN  = 4'd7, // irq enables
    IRQP   = 4'd8, // pending = status & enable
    CTRL   = 4'd9  // fifo flush pulses
  } reg_e;

  // --------------------
  // port signals
  // --------------------
  typedef struct packed {
    logic             wr;    // write strobe
    logic             rd;    // read strobe
    logic [IDX_W-1:0] idx;   // raw index, may be out of map
    data_t            wdata;
  } mbox_req_t;

  typedef struct packed {
    logic  valid; // one cycle after the request
    logic  err;
    data_t rdata;
  } mbox_rsp_t;

  // marker words
  localparam data_t MBOXW_READ_WORD = 32'hFEEDC0DE; // MBOXW is write only
  localparam data_t EMPTY_READ_WORD = 32'hFEEDDEAD; // MBOXR read while empty

endpackage

`default_nettype wire

/* rtl/mbox_fifo.sv */
// one-direction mailbox fifo
// circular buffer with read / write pointers and a fill count
// head word visible without a pop
// flush empties on the next edge
`default_nettype none

module mbox_fifo
  import mbox_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  logic   flush_i,  // drops all words and beats a push
  input  logic   push_i,
  input  logic   pop_i,
  input  data_t  wdata_i,
  output data_t  rdata_o,  // head word
  output logic   full_o,
  output logic   empty_o,
  output usage_t usage_o
);

  data_t              mem_q [MBOX_DEPTH]; // word storage
  logic   [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  usage_t             count_q;
  logic               do_push, do_pop;    // qualified strobes

  assign full_o  = (count_q == usage_t'(MBOX_DEPTH));
  assign empty_o = (count_q == '0);
  assign usage_o = count_q;
  assign rdata_o = mem_q[rd_ptr_q];

  // overflow / underflow attempts are dropped here
  assign do_push = push_i & ~full_o & ~flush_i;
  assign do_pop  = pop_i & ~empty_o & ~flush_i;

  // --------------------
  // pointers and count
  // --------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0; // back to a clean start
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(MBOX_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(MBOX_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ; // idle or push and pop cancel out
      endcase
    end
  end

  // data write
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/mbox_port_regs.sv */
// register block of one mailbox port
// access decode of the ten-register map
// usage thresholds, error register, sticky irq status
// registered response and level irq output
`default_nettype none

module mbox_port_regs
  import mbox_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  mbox_req_t req_i,
  output mbox_rsp_t rsp_o,
  output logic      irq_o,        // active high level
  // outbound fifo, this port pushes
  output logic      push_o,
  output data_t     push_data_o,
  input  logic      out_full_i,
  input  usage_t    out_usage_i,
  output logic      out_flush_o,
  // inbound fifo, this port pops
  output logic      pop_o,
  input  data_t     in_data_i,
  input  logic      in_empty_i,
  input  usage_t    in_usage_i,
  output logic      in_flush_o
);

  mbox_rsp_t  rsp_d, rsp_q;
  logic [1:0] error_d, error_q;   // bit 0 empty read, bit 1 full write
  usage_t     wirqt_d, wirqt_q;   // thresholds, never above MBOX_DEPTH-1
  usage_t     rirqt_d, rirqt_q;
  logic [2:0] irqs_d, irqs_q;     // bit 0 write thr, bit 1 read thr, bit 2 error
  logic [2:0] irqen_d, irqen_q;
  logic [2:0] irqp;               // pending
  logic [2:0] irqs_clr, irqs_set;
  logic [3:0] status;             // read only, built from fifo flags
  logic       err_new;            // access error in this cycle

  // clamp so the threshold can still fire at a full fifo
  function automatic usage_t clamp_thr(data_t val);
    if (val >= data_t'(MBOX_DEPTH)) begin
      return usage_t'(MBOX_DEPTH - 1);
    end
    return usage_t'(val);
  endfunction

  assign status = {in_usage_i > rirqt_q,  // inbound above read threshold
                   out_usage_i > wirqt_q, // outbound above write threshold
                   out_full_i,
                   in_empty_i};

  assign irqp        = irqs_q & irqen_q;
  assign irq_o       = |irqp;
  assign push_data_o = req_i.wdata; // full word, no strobes
  assign rsp_o       = rsp_q;

  // --------------------
  // access decode
  // --------------------
  always_comb begin
    rsp_d       = '0;
    rsp_d.valid = req_i.wr | req_i.rd;
    error_d     = error_q;
    wirqt_d     = wirqt_q;
    rirqt_d     = rirqt_q;
    irqen_d     = irqen_q;
    irqs_clr    = '0;
    err_new     = 1'b0;
    push_o      = 1'b0;
    pop_o       = 1'b0;
    out_flush_o = 1'b0;
    in_flush_o  = 1'b0;

    if (req_i.rd) begin
      case (reg_e'(req_i.idx))
        MBOXW:  rsp_d.rdata = MBOXW_READ_WORD;
        MBOXR: begin
          if (in_empty_i) begin
            rsp_d.rdata = EMPTY_READ_WORD;
            rsp_d.err   = 1'b1;
            error_d[0]  = 1'b1;
            err_new     = 1'b1;
          end else begin
            rsp_d.rdata = in_data_i; // head word, popped on this edge
            pop_o       = 1'b1;
          end
        end
        STATUS: rsp_d.rdata = data_t'(status);
        ERROR: begin
          rsp_d.rdata = data_t'(error_q);
          error_d     = '0;          // clear on read
        end
        WIRQT:  rsp_d.rdata = data_t'(wirqt_q);
        RIRQT:  rsp_d.rdata = data_t'(rirqt_q);
        IRQS:   rsp_d.rdata = data_t'(irqs_q);
        IRQEN:  rsp_d.rdata = data_t'(irqen_q);
        IRQP:   rsp_d.rdata = data_t'(irqp);
        CTRL:   rsp_d.rdata = '0; // flush pulses are already over
        default: rsp_d.err = 1'b1; // unmapped index
      endcase
    end else if (req_i.wr) begin
      case (reg_e'(req_i.idx))
        MBOXW: begin
          if (out_full_i) begin
            rsp_d.err  = 1'b1;
            error_d[1] = 1'b1;
            err_new    = 1'b1;
          end else begin
            push_o = 1'b1;
          end
        end
        WIRQT:  wirqt_d  = clamp_thr(req_i.wdata);
        RIRQT:  rirqt_d  = clamp_thr(req_i.wdata);
        IRQS:   irqs_clr = req_i.wdata[2:0]; // write 1 to clear
        IRQEN:  irqen_d  = req_i.wdata[2:0];
        CTRL: begin
          out_flush_o = req_i.wdata[0];
          in_flush_o  = req_i.wdata[1];
        end
        MBOXR, STATUS, ERROR, IRQP: ; // read only, write dropped
        default: rsp_d.err = 1'b1;
      endcase
    end

    // set conditions beat a clear in the same cycle
    irqs_set = {err_new, status[3], status[2]};
    irqs_d   = (irqs_q & ~irqs_clr) | irqs_set;
  end

  // --------------------
  // state
  // --------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_q   <= '0;
      error_q <= '0;
      wirqt_q <= '0;
      rirqt_q <= '0;
      irqs_q  <= '0;
      irqen_q <= '0;
    end else begin
      rsp_q   <= rsp_d;   // response shows one cycle after the request
      error_q <= error_d;
      wirqt_q <= wirqt_d;
      rirqt_q <= rirqt_d;
      irqs_q  <= irqs_d;
      irqen_q <= irqen_d;
    end
  end

endmodule

`default_nettype wire

/* rtl/mbox_top.sv */
// two-port mailbox top level
// two port register blocks
// fifo_0to1 and fifo_1to0 cross-connect them
// flush requests ORed per fifo
`default_nettype none

module mbox_top
  import mbox_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  mbox_req_t [1:0] req_i,
  output mbox_rsp_t [1:0] rsp_o,
  output logic      [1:0] irq_o
);

  // index 0 is fifo_0to1 and index 1 is fifo_1to0
  // port f pushes into fifo f and pops fifo 1-f
  logic   [1:0] push, pop;
  logic   [1:0] full, empty;
  logic   [1:0] w_flush, r_flush; // from the pushing / popping side
  logic   [1:0] fifo_flush;
  data_t  [1:0] push_data, head;
  usage_t [1:0] usage;

  assign fifo_flush = w_flush | r_flush;

  mbox_port_regs u_port0 (
    .clk_i,
    .rst_n_i,
    .req_i       ( req_i[0]     ),
    .rsp_o       ( rsp_o[0]     ),
    .irq_o       ( irq_o[0]     ),
    .push_o      ( push[0]      ), // outbound is fifo_0to1
    .push_data_o ( push_data[0] ),
    .out_full_i  ( full[0]      ),
    .out_usage_i ( usage[0]     ),
    .out_flush_o ( w_flush[0]   ),
    .pop_o       ( pop[1]       ), // inbound is fifo_1to0
    .in_data_i   ( head[1]      ),
    .in_empty_i  ( empty[1]     ),
    .in_usage_i  ( usage[1]     ),
    .in_flush_o  ( r_flush[1]   )
  );

  mbox_port_regs u_port1 (
    .clk_i,
    .rst_n_i,
    .req_i       ( req_i[1]     ),
    .rsp_o       ( rsp_o[1]     ),
    .irq_o       ( irq_o[1]     ),
    .push_o      ( push[1]      ), // mirror of port 0
    .push_data_o ( push_data[1] ),
    .out_full_i  ( full[1]      ),
    .out_usage_i ( usage[1]     ),
    .out_flush_o ( w_flush[1]   ),
    .pop_o       ( pop[0]       ),
    .in_data_i   ( head[0]      ),
    .in_empty_i  ( empty[0]     ),
    .in_usage_i  ( usage[0]     ),
    .in_flush_o  ( r_flush[0]   )
  );

  // --------------------
  // mailbox fifos
  // --------------------
  mbox_fifo fifo_0to1 (
    .clk_i,
    .rst_n_i,
    .flush_i ( fifo_flush[0] ),
    .push_i  ( push[0]       ),
    .pop_i   ( pop[0]        ),
    .wdata_i ( push_data[0]  ),
    .rdata_o ( head[0]       ),
    .full_o  ( full[0]       ),
    .empty_o ( empty[0]      ),
    .usage_o ( usage[0]      )
  );

  mbox_fifo fifo_1to0 (
    .clk_i,
    .rst_n_i,
    .flush_i ( fifo_flush[1] ),
    .push_i  ( push[1]       ),
    .pop_i   ( pop[1]        ),
    .wdata_i ( push_data[1]  ),
    .rdata_o ( head[1]       ),
    .full_o  ( full[1]       ),
    .empty_o ( empty[1]      ),
    .usage_o ( usage[1]      )
  );

endmodule

`default_nettype wire

/* verif/mbox_props.sv */
// concurrent checks bound to the mailbox top level
// one strobe per request, response exactly one cycle later
// no fifo push while full, no pop while empty
`default_nettype none

module mbox_props
  import mbox_pkg::*;
(
  input logic            clk_i,
  input logic            rst_n_i,
  input mbox_req_t [1:0] req_i,
  input mbox_rsp_t [1:0] rsp_i,
  input logic      [1:0] push_i,  // index is the fifo
  input logic      [1:0] pop_i,
  input logic      [1:0] full_i,
  input logic      [1:0] empty_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned assert_fails = 0; // read by the testbench top

  for (genvar p = 0; p < 2; p++) begin : g_port
    a_one_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(req_i[p].wr && req_i[p].rd))
      else begin
        assert_fails++;
        $error("port %0d drives wr and rd in the same cycle", p);
      end

    a_rsp_follows: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (req_i[p].wr || req_i[p].rd) |=> rsp_i[p].valid)
      else begin
        assert_fails++;
        $error("port %0d gave no response one cycle after a request", p);
      end

    a_no_spurious: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(req_i[p].wr || req_i[p].rd) |=> !rsp_i[p].valid)
      else begin
        assert_fails++;
        $error("port %0d gave a response without a request", p);
      end

    // fifo p here, not port p
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(push_i[p] && full_i[p]))
      else begin
        assert_fails++;
        $error("fifo %0d pushed while full", p);
      end

    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(pop_i[p] && empty_i[p]))
      else begin
        assert_fails++;
        $error("fifo %0d popped while empty", p);
      end
  end

endmodule

`default_nettype wire

/* verif/mbox_checker.sv */
// mailbox checker
// reference model of both register blocks and both fifos
// response and irq comparison, error and check counters
`default_nettype none

module mbox_checker
  import mbox_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  mbox_req_t [1:0] req_i,
  input  mbox_rsp_t [1:0] rsp_i,
  input  logic      [1:0] irq_i,
  output int unsigned     errors_o,
  output int unsigned     checks_o
);
  timeunit 1ns;
  timeprecision 1ps;

  data_t      fifo_m [2][$]; // index is the pushing port
  logic [1:0] err_m [2];
  usage_t     wthr_m [2];
  usage_t     rthr_m [2];
  logic [2:0] irqs_m [2];
  logic [2:0] irqen_m [2];
  mbox_rsp_t  exp_rsp [2];   // shown in the cycle after the request
  logic       exp_rd [2];    // rdata only matters for reads

  // STATUS of port p from the fill levels before the edge
  function automatic logic [3:0] status_of(int p);
    int unsigned out_n;
    int unsigned in_n;
    out_n = fifo_m[p].size();
    in_n  = fifo_m[1-p].size();
    return {in_n > rthr_m[p], out_n > wthr_m[p], out_n == MBOX_DEPTH, in_n == 0};
  endfunction

  function automatic usage_t limit_thr(data_t d);
    if (d > MBOX_DEPTH - 1) begin
      return usage_t'(MBOX_DEPTH - 1);
    end
    return usage_t'(d);
  endfunction

  initial begin
    errors_o = 0;
    checks_o = 0;
  end

  // --------------------
  // model, one step per sampled edge
  // --------------------
  always @(posedge clk_i or negedge rst_n_i) begin : model
    logic [1:0] flush, pop, push; // per fifo
    data_t      push_val [2];
    logic [2:0] set;
    logic [3:0] st;
    mbox_req_t  r;
    if (!rst_n_i) begin
      for (int p = 0; p < 2; p++) begin
        fifo_m[p].delete();
        err_m[p]   = '0;
        wthr_m[p]  = '0;
        rthr_m[p]  = '0;
        irqs_m[p]  = '0;
        irqen_m[p] = '0;
        exp_rsp[p] = '0;
        exp_rd[p]  = 1'b0;
      end
    end else begin
      flush = '0;
      pop   = '0;
      push  = '0;
      for (int p = 0; p < 2; p++) begin
        r                = req_i[p];
        st               = status_of(p);
        set              = {1'b0, st[3], st[2]}; // threshold conditions
        exp_rsp[p]       = '0;
        exp_rsp[p].valid = r.wr | r.rd;
        exp_rd[p]        = r.rd;
        if (r.rd) begin
          case (r.idx)
            MBOXW:  exp_rsp[p].rdata = MBOXW_READ_WORD;
            MBOXR: begin
              if (st[0]) begin
                exp_rsp[p].rdata = EMPTY_READ_WORD;
                exp_rsp[p].err   = 1'b1;
                err_m[p][0]      = 1'b1;
                set[2]           = 1'b1;
              end else begin
                exp_rsp[p].rdata = fifo_m[1-p][0]; // oldest word from the peer
                pop[1-p]         = 1'b1;
              end
            end
            STATUS: exp_rsp[p].rdata = data_t'(st);
            ERROR: begin
              exp_rsp[p].rdata = data_t'(err_m[p]);
              err_m[p]         = '0;
            end
            WIRQT:  exp_rsp[p].rdata = data_t'(wthr_m[p]);
            RIRQT:  exp_rsp[p].rdata = data_t'(rthr_m[p]);
            IRQS:   exp_rsp[p].rdata = data_t'(irqs_m[p]);
            IRQEN:  exp_rsp[p].rdata = data_t'(irqen_m[p]);
            IRQP:   exp_rsp[p].rdata = data_t'(irqs_m[p] & irqen_m[p]);
            CTRL:   ; // reads zero
            default: exp_rsp[p].err = 1'b1;
          endcase
        end else if (r.wr) begin
          case (r.idx)
            MBOXW: begin
              if (st[1]) begin
                exp_rsp[p].err = 1'b1; // outbound full
                err_m[p][1]    = 1'b1;
                set[2]         = 1'b1;
              end else begin
                push[p]     = 1'b1;
                push_val[p] = r.wdata;
              end
            end
            WIRQT: wthr_m[p]  = limit_thr(r.wdata);
            RIRQT: rthr_m[p]  = limit_thr(r.wdata);
            IRQS:  irqs_m[p]  = irqs_m[p] & ~r.wdata[2:0];
            IRQEN: irqen_m[p] = r.wdata[2:0];
            CTRL: begin
              flush[p]   = flush[p] | r.wdata[0];   // own outbound
              flush[1-p] = flush[1-p] | r.wdata[1]; // inbound from the peer
            end
            MBOXR, STATUS, ERROR, IRQP: ;
            default: exp_rsp[p].err = 1'b1;
          endcase
        end
        irqs_m[p] = irqs_m[p] | set; // a set beats a clear
      end
      for (int f = 0; f < 2; f++) begin
        if (flush[f]) begin
          fifo_m[f].delete(); // also drops a push of this cycle
        end else begin
          if (pop[f]) begin
            void'(fifo_m[f].pop_front());
          end
          if (push[f]) begin
            fifo_m[f].push_back(push_val[f]);
          end
        end
      end
    end
  end

  // --------------------
  // compare at the falling edge
  // --------------------
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      for (int p = 0; p < 2; p++) begin
        checks_o++;
        if (rsp_i[p].valid !== exp_rsp[p].valid) begin
          errors_o++;
          if (exp_rsp[p].valid) begin
            $display("port %0d: no response in the cycle after the request", p);
          end else begin
            $display("port %0d: response valid without a request", p);
          end
        end else if (exp_rsp[p].valid) begin
          if (rsp_i[p].err !== exp_rsp[p].err) begin
            errors_o++;
            $display("Mismatch rsp_o[%0d].err: expected %h, actual %h",
                     p, exp_rsp[p].err, rsp_i[p].err);
          end
          if (exp_rd[p] && (rsp_i[p].rdata !== exp_rsp[p].rdata)) begin
            errors_o++;
            $display("Mismatch rsp_o[%0d].rdata: expected %h, actual %h",
                     p, exp_rsp[p].rdata, rsp_i[p].rdata);
          end
        end
        if (irq_i[p] !== (|(irqs_m[p] & irqen_m[p]))) begin
          errors_o++;
          $display("Mismatch irq_o[%0d]: expected %h, actual %h",
                   p, |(irqs_m[p] & irqen_m[p]), irq_i[p]);
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verif/mbox_tb.sv */
// mailbox testbench top
// clock, reset, DUT, checker and bound assertions
// directed and seeded random stimulus in three tests
// cycle limit and final verdict
`default_nettype none

module mbox_tb
  import mbox_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned CYCLE_LIMIT = 5 + 3 * 450 * 2; // reset plus three tests

  logic            clk;
  logic            rst_n;
  mbox_req_t [1:0] req;
  mbox_rsp_t [1:0] rsp;
  logic      [1:0] irq;
  int unsigned     errors, checks;
  int unsigned     errors_before;
  int unsigned     cycles;
  integer          seed;

  mbox_top dut0 (
    .clk_i   ( clk   ),
    .rst_n_i ( rst_n ),
    .req_i   ( req   ),
    .rsp_o   ( rsp   ),
    .irq_o   ( irq   )
  );

  mbox_checker u_chk (
    .clk_i    ( clk    ),
    .rst_n_i  ( rst_n  ),
    .req_i    ( req    ),
    .rsp_i    ( rsp    ),
    .irq_i    ( irq    ),
    .errors_o ( errors ),
    .checks_o ( checks )
  );

  // fifo flags and strobes come from inside the top level
  bind mbox_top mbox_props u_props (
    .clk_i,
    .rst_n_i,
    .req_i,
    .rsp_i   ( rsp_o ),
    .push_i  ( push  ),
    .pop_i   ( pop   ),
    .full_i  ( full  ),
    .empty_i ( empty )
  );

  always #10 clk = ~clk;

  function automatic int unsigned total_errors();
    return errors + dut0.u_props.assert_fails;
  endfunction

  // one cycle of requests on both ports
  task automatic step(input mbox_req_t r0, input mbox_req_t r1);
    @(posedge clk);
    req[0] <= r0;
    req[1] <= r1;
  endtask

  // one access on a single port, the other port idles
  task automatic access(input int port, input logic wr, input logic [3:0] idx, input data_t d);
    mbox_req_t r;
    r = '{wr: wr, rd: ~wr, idx: idx, wdata: d};
    if (port == 0) begin
      step(r, '0);
    end else begin
      step('0, r);
    end
  endtask

  // mostly mailbox traffic, some register accesses, some idle
  function automatic mbox_req_t rand_req();
    mbox_req_t   r;
    int unsigned sel;
    r       = '0;
    sel     = $unsigned($random(seed)) % 10;
    r.wdata = $random(seed);
    if (sel < 4) begin
      r.wr  = 1'b1;
      r.idx = MBOXW;
    end else if (sel < 7) begin
      r.rd  = 1'b1;
      r.idx = MBOXR;
    end else if (sel < 9) begin
      r.idx = 4'($unsigned($random(seed)) % 16); // unmapped slots too
      r.wr  = $random(seed) & 1;
      r.rd  = ~r.wr;
    end
    return r;
  endfunction

  task automatic end_test(input int n, input string name);
    repeat (3) step('0, '0); // let the last responses drain
    $display("test %0d %s finished, %0d errors", n, name, total_errors() - errors_before);
    errors_before = total_errors();
  endtask

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    req           = '0;
    errors_before = 0;
    seed          = 32'hb508;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    // ---------------- test 1, fill and drain
    access(1, 0, MBOXR, '0); // empty read
    for (int i = 0; i <= MBOX_DEPTH; i++) begin
      access(0, 1, MBOXW, 32'hA000_0000 + i); // last one hits a full fifo
    end
    access(0, 0, STATUS, '0);
    access(1, 0, STATUS, '0);
    for (int i = 0; i < MBOX_DEPTH; i++) begin
      access(1, 0, MBOXR, '0);
    end
    for (int p = 0; p < 2; p++) begin
      access(p, 0, ERROR, '0);
      access(p, 0, ERROR, '0); // cleared by the read before
      access(p, 1, IRQEN, 32'h7);
      access(p, 0, IRQS, '0);
      access(p, 1, IRQS, 32'h7);
      access(p, 0, IRQP, '0);
    end
    for (int i = 0; i < 3; i++) begin
      access(1, 1, MBOXW, 32'hB000_0000 + i);
    end
    for (int i = 0; i < 4; i++) begin
      access(0, 0, MBOXR, '0);
    end
    access(0, 0, MBOXW, '0);
    access(0, 0, CTRL, '0);
    access(1, 0, 4'd12, '0);
    access(1, 1, 4'd15, '1);
    end_test(1, "fill and drain");

    // ---------------- test 2, random traffic on both ports
    for (int i = 0; i < 400; i++) begin
      step(rand_req(), rand_req());
    end
    end_test(2, "random traffic");

    // ---------------- test 3, flush and thresholds
    for (int p = 0; p < 2; p++) begin
      access(p, 1, CTRL, 32'h3);
      access(p, 1, IRQEN, '0);
      access(p, 1, IRQS, 32'h7);
      access(p, 0, ERROR, '0);
    end
    access(0, 1, WIRQT, 32'd20); // above the depth
    access(0, 0, WIRQT, '0);
    access(1, 1, RIRQT, 32'd3);
    access(1, 0, RIRQT, '0);
    access(0, 1, WIRQT, 32'd2);
    access(0, 1, IRQEN, 32'h1);
    access(1, 1, IRQEN, 32'h2);
    for (int i = 0; i < 5; i++) begin
      access(0, 1, MBOXW, 32'hC000_0000 + i);
      access(0, 0, STATUS, '0);
      access(1, 0, STATUS, '0);
    end
    access(0, 1, CTRL, 32'h1); // sender flushes fifo_0to1
    access(1, 0, MBOXR, '0);
    access(0, 1, IRQS, 32'h7);
    access(1, 1, IRQS, 32'h7);
    for (int i = 0; i < 3; i++) begin
      access(0, 1, MBOXW, 32'hD000_0000 + i);
    end
    access(1, 1, CTRL, 32'h2); // receiver flushes fifo_0to1
    access(1, 0, MBOXR, '0);
    for (int i = 0; i < 2; i++) begin
      access(1, 1, MBOXW, 32'hE000_0000 + i);
    end
    access(0, 1, CTRL, 32'h2);
    access(0, 0, MBOXR, '0);
    access(0, 0, IRQP, '0);
    access(1, 0, IRQP, '0);
    end_test(3, "flush and thresholds");

    $display("checks %0d, checker errors %0d, assertion failures %0d",
             checks, errors, dut0.u_props.assert_fails);
    if (total_errors() == 0 && checks > 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // cycle limit
  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, run did not end within %0d cycles", CYCLE_LIMIT);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
rtl/mbox_pkg.sv
rtl/mbox_fifo.sv
rtl/mbox_port_regs.sv
rtl/mbox_top.sv
verif/mbox_props.sv
verif/mbox_checker.sv
verif/mbox_tb.sv

/* Bender.yml */
package:
  name: mbox

sources:
  # design
  - files:
      - rtl/mbox_pkg.sv
      - rtl/mbox_fifo.sv
      - rtl/mbox_port_regs.sv
      - rtl/mbox_top.sv

  # testbench
  - target: test
    files:
      - verif/mbox_props.sv
      - verif/mbox_checker.sv
      - verif/mbox_tb.sv
